//--- verilog.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/exu_pkg.sv
hdl/exu_decode.sv
hdl/exu_alu.sv
hdl/exu_branch.sv
hdl/exu_writeback.sv
hdl/exu_top.sv
tests/exu_chk.sv
tests/exu_tb.sv

//--- Makefile
TOOL     = verilator
TOP      = exu_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir
RUNARGS  = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP) $(RUNARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(TOOL) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

//--- tests/exu_tb.sv
`include "exu_settings.svh"

module exu_tb
   import exu_pkg::*;
;

   // major opcodes from the ISA encoding
   localparam logic [6:0] OP = 7'h33;
   localparam logic [6:0] OP_IMM = 7'h13;
   localparam logic [6:0] LUI = 7'h37;
   localparam logic [6:0] AUIPC = 7'h17;
   localparam logic [6:0] JAL = 7'h6f;
   localparam logic [6:0] JALR = 7'h67;
   localparam logic [6:0] BRANCH = 7'h63;

   localparam int N_ALU = 200;
   localparam int N_UPPER = 60;
   localparam int N_BR = 90;
   localparam int N_MIX = 120;
   localparam int N_ILL = 40;
   localparam int DRAIN = 2;
   localparam int STIM_CYCLES = 4 + N_ALU + N_UPPER + N_BR + N_MIX + N_ILL + 6 * (DRAIN + 1);
   localparam int TIMEOUT = 2 * STIM_CYCLES + 50;

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 valid;
   logic [31:0]          insn;
   logic [`EXU_XLEN-1:0] pc;
   logic [`EXU_XLEN-1:0] rs1;
   logic [`EXU_XLEN-1:0] rs2;
   exu_resp_t            resp;

   logic [31:0] seed = 32'he791;
   logic        pend_reset = 1'b1;
   logic        pend_valid = 1'b0;
   logic        have_last = 1'b0;
   exu_resp_t   pend_exp;
   exu_resp_t   last_exp;
   exu_resp_t   idle_exp;
   int          cycles = 0;
   int          checks = 0;
   int          errors = 0;
   int          mark_checks = 0;
   int          mark_errors = 0;

   exu_top uut (
      .i_clk   (clk),
      .i_reset (reset),
      .i_valid (valid),
      .i_insn  (insn),
      .i_pc    (pc),
      .i_rs1   (rs1),
      .i_rs2   (rs2),
      .o_resp  (resp)
   );

   always #10 clk = ~clk;

   // ##################################################
   // random numbers and reference model
   // ##################################################

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic draw(output logic [31:0] v);
      logic [31:0] hi;
      seed = lcg_next(seed);
      hi = seed;
      seed = lcg_next(seed);
      v = {hi[31:16], seed[31:16]};
   endtask

   task automatic draw64(output logic [63:0] v);
      logic [31:0] x;
      logic [31:0] y;
      draw(x);
      draw(y);
      v = {x, y};
   endtask

   // funct3 values shared by the alu ops and the branches
   function automatic logic [2:0] pick_f3(input logic [31:0] r);
      case (r[31:16] % 6)
         0: return 3'd0;
         1: return 3'd1;
         2: return 3'd4;
         3: return 3'd5;
         4: return 3'd6;
         default: return 3'd7;
      endcase
   endfunction

   function automatic logic known_opcode(input logic [6:0] op);
      return op == OP || op == OP_IMM || op == LUI || op == AUIPC ||
             op == JAL || op == JALR || op == BRANCH;
   endfunction

   function automatic exu_resp_t exu_model(input logic [31:0] w, input logic [63:0] p,
                                           input logic [63:0] a, input logic [63:0] b);
      exu_resp_t   m;
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [63:0] imm_i;
      logic [63:0] imm_u;
      logic [63:0] imm_b;
      logic [63:0] imm_j;
      logic [63:0] op2;
      logic [63:0] res;
      logic [6:0]  sh;
      logic [61:0] tgt;
      logic        ok;
      logic        take;
      logic        is_br;
      opc = w[6:0];
      f3 = w[14:12];
      f7 = w[31:25];
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_u = {{32{w[31]}}, w[31:12], 12'h000};
      imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      res = '0;
      tgt = '0;
      ok = 1'b1;
      take = 1'b0;
      is_br = 1'b0;
      op2 = (opc == OP) ? b : imm_i;
      sh = op2[6:0];
      case (opc)
         LUI: res = imm_u;
         AUIPC: res = p + imm_u;
         JAL: begin
            res = {p[63:2], 2'b00} + 64'd4;
            tgt = p[63:2] + imm_j[63:2];
            take = 1'b1;
         end
         JALR: begin
            ok = (f3 == 3'd0);
            res = {p[63:2], 2'b00} + 64'd4;
            // word parts added alone with the low bits of rs1 dropped
            tgt = a[63:2] + imm_i[63:2];
            take = 1'b1;
         end
         OP, OP_IMM: begin
            if (opc == OP && f7 != 7'h00 && !(f7 == 7'h20 && f3 == 3'd0))
               ok = 1'b0;
            if (opc == OP_IMM && (f3 == 3'd1 || f3 == 3'd5) && w[31:26] != 6'd0)
               ok = 1'b0;
            case (f3)
               3'd0: res = (opc == OP && f7 == 7'h20) ? a - op2 : a + op2;
               3'd1: res = (sh < 7'd64) ? a << sh : '0;
               3'd4: res = a ^ op2;
               3'd5: res = (sh < 7'd64) ? a >> sh : '0;
               3'd6: res = a | op2;
               3'd7: res = a & op2;
               default: ok = 1'b0;
            endcase
         end
         BRANCH: begin
            is_br = 1'b1;
            tgt = p[63:2] + imm_b[63:2];
            case (f3)
               3'd0: take = (a == b);
               3'd1: take = (a != b);
               3'd4: take = ($signed(a) < $signed(b));
               3'd5: take = ($signed(a) >= $signed(b));
               3'd6: take = (a < b);
               3'd7: take = (a >= b);
               default: ok = 1'b0;
            endcase
         end
         default: ok = 1'b0;
      endcase
      m.valid = 1'b1;
      m.illegal = ~ok;
      m.rd = (ok && !is_br) ? w[11:7] : 5'd0;
      m.result = ok ? res : '0;
      m.redirect = ok & take;
      m.pc_tgt = m.redirect ? tgt : '0;
      return m;
   endfunction

   // ##################################################
   // compare tasks
   // ##################################################

   task automatic check_result(input exu_resp_t got, input exu_resp_t exp);
      checks++;
      if (got.result !== exp.result || got.rd !== exp.rd) begin
         errors++;
         $display("[ERROR] %0t: result %h rd %0d, expected %h rd %0d",
                  $time, got.result, got.rd, exp.result, exp.rd);
      end
   endtask

   task automatic check_redirect(input exu_resp_t got, input exu_resp_t exp);
      checks++;
      if (got.redirect !== exp.redirect || got.pc_tgt !== exp.pc_tgt) begin
         errors++;
         $display("[ERROR] %0t: redirect %b pc_tgt %h, expected %b pc_tgt %h",
                  $time, got.redirect, got.pc_tgt, exp.redirect, exp.pc_tgt);
      end
   endtask

   task automatic check_flags(input exu_resp_t got, input exu_resp_t exp);
      checks++;
      if (got.valid !== exp.valid || got.illegal !== exp.illegal ||
          got.redirect !== exp.redirect) begin
         errors++;
         $display("[ERROR] %0t: valid %b illegal %b redirect %b, expected %b %b %b",
                  $time, got.valid, got.illegal, got.redirect,
                  exp.valid, exp.illegal, exp.redirect);
      end
   endtask

   // ##################################################
   // expected response pipeline and compare
   // ##################################################

   always @(posedge clk) begin
      pend_reset <= reset;
      pend_valid <= valid & ~reset;
      if (valid & ~reset)
         pend_exp <= exu_model(insn, pc, rs1, rs2);
   end

   always @(negedge clk) begin
      if (pend_reset) begin
         last_exp = '0;
         have_last = 1'b0;
      end else if (pend_valid) begin
         check_flags(resp, pend_exp);
         check_result(resp, pend_exp);
         check_redirect(resp, pend_exp);
         last_exp = pend_exp;
         have_last = 1'b1;
      end else begin
         // idle cycle holds everything but valid
         idle_exp = last_exp;
         idle_exp.valid = 1'b0;
         check_flags(resp, idle_exp);
         if (have_last) begin
            check_result(resp, idle_exp);
            check_redirect(resp, idle_exp);
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout: tests did not finish within %0d cycles", TIMEOUT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ##################################################
   // stimulus
   // ##################################################

   task automatic send(input logic [31:0] w, input logic [63:0] p,
                       input logic [63:0] a, input logic [63:0] b);
      @(posedge clk);
      valid <= 1'b1;
      insn <= w;
      pc <= p;
      rs1 <= a;
      rs2 <= b;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         valid <= 1'b0;
      end
   endtask

   task automatic close_test(input int num, input string name);
      idle(DRAIN);
      @(posedge clk);
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               checks - mark_checks, errors - mark_errors);
      mark_checks = checks;
      mark_errors = errors;
   endtask

   task automatic rand_alu(output logic [31:0] w);
      logic [31:0] r;
      logic [2:0]  f3;
      draw(w);
      draw(r);
      f3 = pick_f3(r);
      w[14:12] = f3;
      if (r[0]) begin
         w[6:0] = OP;
         w[31:25] = (f3 == 3'd0 && r[1]) ? 7'h20 : 7'h00;
      end else begin
         w[6:0] = OP_IMM;
         if (f3 == 3'd1 || f3 == 3'd5)
            w[31:26] = 6'd0;
      end
   endtask

   initial begin
      logic [31:0] w;
      logic [31:0] r;
      logic [63:0] p;
      logic [63:0] a;
      logic [63:0] b;
      reset <= 1'b1;
      valid <= 1'b0;
      insn <= '0;
      pc <= '0;
      rs1 <= '0;
      rs2 <= '0;

      repeat (2) begin
         @(posedge clk);
         @(negedge clk);
         check_flags(resp, '0);
      end
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_flags(resp, '0);
      @(negedge clk);
      check_flags(resp, '0);
      close_test(1, "reset");

      repeat (N_ALU) begin
         rand_alu(w);
         draw64(p);
         draw64(a);
         draw64(b);
         send(w, p, a, b);
      end
      close_test(2, "alu ops and shifts");

      repeat (N_UPPER) begin
         draw(w);
         draw(r);
         draw64(p);
         draw64(a);
         draw64(b);
         case (r[31:30])
            2'd0: w[6:0] = LUI;
            2'd1: w[6:0] = AUIPC;
            2'd2: w[6:0] = JAL;
            default: begin
               w[6:0] = JALR;
               w[14:12] = 3'd0;
            end
         endcase
         send(w, p, a, b);
      end
      close_test(3, "upper immediates and jumps");

      repeat (N_BR) begin
         draw(w);
         draw(r);
         draw64(p);
         draw64(a);
         draw64(b);
         w[6:0] = BRANCH;
         w[14:12] = pick_f3(r);
         // equal, greater, less or unrelated operands
         case (r[3:2])
            2'd0: b = a;
            2'd1: b = a + {48'd0, r[15:0]} + 64'd1;
            2'd2: b = a - {48'd0, r[15:0]} - 64'd1;
            default: b = b;
         endcase
         send(w, p, a, b);
      end
      close_test(4, "branches");

      repeat (N_MIX) begin
         draw(r);
         if (r[31]) begin
            rand_alu(w);
            draw64(p);
            draw64(a);
            draw64(b);
            send(w, p, a, b);
         end else begin
            idle(1);
         end
      end
      close_test(5, "back to back with idles");

      repeat (N_ILL) begin
         draw(w);
         draw(r);
         draw64(p);
         draw64(a);
         draw64(b);
         if (r[31]) begin
            while (known_opcode(w[6:0]))
               w[6:0] = w[6:0] + 7'd1;
         end else begin
            // SRA is not supported
            w[6:0] = OP;
            w[14:12] = 3'd5;
            w[31:25] = 7'h20;
         end
         send(w, p, a, b);
      end
      close_test(6, "illegal instructions");

      $display("summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
               checks, errors, uut.u_chk.fail_count);
      if (errors == 0 && uut.u_chk.fail_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- tests/exu_chk.sv
module exu_chk
   import exu_pkg::*;
(
   input logic      i_clk,
   input logic      i_reset,
   input logic      i_valid,
   input exu_resp_t i_resp
);

   int fail_count = 0;

   // ##################################################
   // response protocol
   // ##################################################

   a_reset_quiet: assert property (@(posedge i_clk) i_reset |=> !i_resp.valid)
      else begin
         $error("response valid right after reset");
         fail_count++;
      end

   a_illegal_no_redirect: assert property (@(posedge i_clk) i_resp.illegal |-> !i_resp.redirect)
      else begin
         $error("redirect on an illegal instruction");
         fail_count++;
      end

   // one response per accepted instruction, one cycle later
   a_resp_follows: assert property (@(posedge i_clk) disable iff (i_reset)
      i_valid |=> i_resp.valid)
      else begin
         $error("no response one cycle after valid input");
         fail_count++;
      end

   a_no_extra_resp: assert property (@(posedge i_clk) disable iff (i_reset)
      !i_valid |=> !i_resp.valid)
      else begin
         $error("response without a valid input");
         fail_count++;
      end

endmodule

bind exu_top exu_chk u_chk (
   .i_clk   (i_clk),
   .i_reset (i_reset),
   .i_valid (i_valid),
   .i_resp  (o_resp)
);

//--- hdl/exu_top.sv
`include "exu_settings.svh"

module exu_top
   import rv_isa_pkg::*, exu_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  logic                 i_valid,
   input  rv_insn_u             i_insn,
   input  logic [`EXU_XLEN-1:0] i_pc,
   input  logic [`EXU_XLEN-1:0] i_rs1,
   input  logic [`EXU_XLEN-1:0] i_rs2,
   output exu_resp_t            o_resp
);

   exu_req_t              req;
   logic [`EXU_XLEN-1:0]  alu_result;
   logic                  br_taken;
   logic [`EXU_PCW_W-1:0] br_pc_tgt;

   // decode, alu and branch are all combinational
   exu_decode u_decode (
      .i_valid (i_valid),
      .i_insn  (i_insn),
      .i_pc    (i_pc),
      .i_rs1   (i_rs1),
      .i_rs2   (i_rs2),
      .o_req   (req)
   );

   exu_alu u_alu (
      .i_req    (req),
      .o_result (alu_result)
   );

   exu_branch u_branch (
      .i_req    (req),
      .o_taken  (br_taken),
      .o_pc_tgt (br_pc_tgt)
   );

   // single register stage
   exu_writeback u_writeback (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_req    (req),
      .i_result (alu_result),
      .i_taken  (br_taken),
      .i_pc_tgt (br_pc_tgt),
      .o_resp   (o_resp)
   );

endmodule

//--- hdl/exu_writeback.sv
`include "exu_settings.svh"

module exu_writeback
   import exu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_reset,
   input  exu_req_t              i_req,
   input  logic [`EXU_XLEN-1:0]  i_result,
   input  logic                  i_taken,
   input  logic [`EXU_PCW_W-1:0] i_pc_tgt,
   output exu_resp_t             o_resp
);

   logic [`EXU_XLEN-1:0]  result;
   logic                  redirect;
   logic [`EXU_PCW_W-1:0] pc_tgt;
   exu_resp_t             resp_q;

   // illegal instructions neither write nor redirect
   assign result = i_req.illegal ? '0 : i_result;
   assign redirect = i_taken & ~i_req.illegal;
   assign pc_tgt = redirect ? i_pc_tgt : '0;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         resp_q.valid <= 1'b0;
         resp_q.illegal <= 1'b0;
         resp_q.redirect <= 1'b0;
      end else begin
         resp_q.valid <= i_req.valid;
         // everything else holds while idle
         if (i_req.valid) begin
            resp_q.illegal <= i_req.illegal;
            resp_q.redirect <= redirect;
            resp_q.rd <= i_req.rd;
            resp_q.result <= result;
            resp_q.pc_tgt <= pc_tgt;
         end
      end
   end

   assign o_resp = resp_q;

endmodule

//--- hdl/exu_branch.sv
`include "exu_settings.svh"

module exu_branch
   import exu_pkg::*;
(
   input  exu_req_t              i_req,
   output logic                  o_taken,
   output logic [`EXU_PCW_W-1:0] o_pc_tgt
);

   logic                 cond;
   logic                 jump;
   logic [`EXU_XLEN-1:0] op1;
   logic [`EXU_XLEN-1:0] op2;
   exu_fsel_t            sel;

   assign sel = i_req.fsel;
   assign op1 = i_req.operand1;
   assign op2 = i_req.operand2;

   // ##################################################
   // branch condition
   // ##################################################

   always_comb begin
      cond = 1'b0;
      if (sel[FS_BEQ])
         cond = (op1 == op2);
      else if (sel[FS_BNE])
         cond = (op1 != op2);
      else if (sel[FS_BLT])
         cond = ($signed(op1) < $signed(op2));
      else if (sel[FS_BGE])
         cond = ($signed(op1) >= $signed(op2));
      else if (sel[FS_BLTU])
         cond = (op1 < op2);
      else if (sel[FS_BGEU])
         cond = (op1 >= op2);
      else begin
         cond = 1'b0;
      end
   end

   assign jump = sel[FS_JAL] | sel[FS_JALR];
   assign o_taken = cond | jump;

   // ##################################################
   // target, in word addresses
   // ##################################################

   // low two bits dropped before the add, so no carry out of them
   always_comb begin
      if (sel[FS_JALR])
         o_pc_tgt = op1[`EXU_XLEN-1:2] + i_req.offset[`EXU_XLEN-1:2];
      else if (o_taken)
         o_pc_tgt = i_req.pc[`EXU_XLEN-1:2] + i_req.offset[`EXU_XLEN-1:2];
      else
         o_pc_tgt = '0;
   end

endmodule

//--- hdl/exu_alu.sv
`include "exu_settings.svh"

module exu_alu
   import exu_pkg::*;
(
   input  exu_req_t             i_req,
   output logic [`EXU_XLEN-1:0] o_result
);

   logic [`EXU_XLEN-1:0]    out_lui;
   logic [`EXU_XLEN-1:0]    out_auipc;
   logic [`EXU_XLEN-1:0]    out_link;
   logic [`EXU_XLEN-1:0]    out_add;
   logic [`EXU_XLEN-1:0]    out_sub;
   logic [`EXU_XLEN-1:0]    out_and;
   logic [`EXU_XLEN-1:0]    out_or;
   logic [`EXU_XLEN-1:0]    out_xor;
   logic [`EXU_XLEN-1:0]    out_sll;
   logic [`EXU_XLEN-1:0]    out_srl;
   logic [`EXU_SHAMT_W-1:0] shamt;
   exu_fsel_t               sel;

   assign sel = i_req.fsel;
   assign shamt = i_req.operand2[`EXU_SHAMT_W-1:0];

   // upper immediates
   assign out_lui = i_req.operand2;
   assign out_auipc = i_req.operand2 + i_req.pc;

   // return address, word aligned
   assign out_link = {i_req.pc[`EXU_XLEN-1:2] + 1'b1, 2'b00};

   assign out_add = i_req.operand1 + i_req.operand2;
   assign out_sub = i_req.operand1 - i_req.operand2;
   assign out_and = i_req.operand1 & i_req.operand2;
   assign out_or = i_req.operand1 | i_req.operand2;
   assign out_xor = i_req.operand1 ^ i_req.operand2;

   // logical shifts, 64 and up clears the word
   assign out_sll = i_req.operand1 << shamt;
   assign out_srl = i_req.operand1 >> shamt;

   // ##################################################
   // one-hot and-or mux
   // ##################################################

   // branches and illegal select nothing and give zero
   assign o_result = ({`EXU_XLEN{sel[FS_LUI]}} & out_lui) |
                     ({`EXU_XLEN{sel[FS_AUIPC]}} & out_auipc) |
                     ({`EXU_XLEN{sel[FS_JAL] | sel[FS_JALR]}} & out_link) |
                     ({`EXU_XLEN{sel[FS_ADD]}} & out_add) |
                     ({`EXU_XLEN{sel[FS_SUB]}} & out_sub) |
                     ({`EXU_XLEN{sel[FS_AND]}} & out_and) |
                     ({`EXU_XLEN{sel[FS_OR]}} & out_or) |
                     ({`EXU_XLEN{sel[FS_XOR]}} & out_xor) |
                     ({`EXU_XLEN{sel[FS_SLL]}} & out_sll) |
                     ({`EXU_XLEN{sel[FS_SRL]}} & out_srl);

endmodule

//--- hdl/exu_decode.sv
`include "exu_settings.svh"

module exu_decode
   import rv_isa_pkg::*, exu_pkg::*;
(
   input  logic                 i_valid,
   input  rv_insn_u             i_insn,
   input  logic [`EXU_XLEN-1:0] i_pc,
   input  logic [`EXU_XLEN-1:0] i_rs1,
   input  logic [`EXU_XLEN-1:0] i_rs2,
   output exu_req_t             o_req
);

   logic [`EXU_XLEN-1:0] imm_i;
   logic [`EXU_XLEN-1:0] imm_u;
   logic [`EXU_XLEN-1:0] imm_b;
   logic [`EXU_XLEN-1:0] imm_j;
   logic [`EXU_XLEN-1:0] operand2;
   logic [`EXU_XLEN-1:0] offset;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   exu_fsel_t            fsel;
   logic                 illegal;
   logic                 has_rd;

   // alu op from funct3, none if unknown
   function automatic exu_fsel_t alu_fsel(input logic [2:0] f3, input logic shift_ok);
      exu_fsel_t sel;
      sel = '0;
      case (f3)
         F3_ADD_SUB: sel[FS_ADD] = 1'b1;
         F3_XOR:     sel[FS_XOR] = 1'b1;
         F3_OR:      sel[FS_OR]  = 1'b1;
         F3_AND:     sel[FS_AND] = 1'b1;
         F3_SLL:     sel[FS_SLL] = shift_ok;
         F3_SRL:     sel[FS_SRL] = shift_ok;
         default:    sel = '0;
      endcase
      return sel;
   endfunction

   assign funct3 = i_insn.r.funct3;
   assign funct7 = i_insn.r.funct7;

   // immediates from the matching view
   assign imm_i = {{(`EXU_XLEN-12){i_insn.i.imm[11]}}, i_insn.i.imm};
   assign imm_u = {{(`EXU_XLEN-32){i_insn.u.imm[19]}}, i_insn.u.imm, 12'b0};
   assign imm_b = {{(`EXU_XLEN-12){i_insn.b.imm12}}, i_insn.b.imm11,
                   i_insn.b.imm10_5, i_insn.b.imm4_1, 1'b0};
   assign imm_j = {{(`EXU_XLEN-20){i_insn.j.imm20}}, i_insn.j.imm19_12,
                   i_insn.j.imm11, i_insn.j.imm10_1, 1'b0};

   always_comb begin
      fsel = '0;
      operand2 = i_rs2;
      offset = '0;
      case (i_insn.r.opcode)
         OPC_LUI: begin
            fsel[FS_LUI] = 1'b1;
            operand2 = imm_u;
         end
         OPC_AUIPC: begin
            fsel[FS_AUIPC] = 1'b1;
            operand2 = imm_u;
         end
         OPC_JAL: begin
            fsel[FS_JAL] = 1'b1;
            offset = imm_j;
         end
         OPC_JALR: begin
            fsel[FS_JALR] = (funct3 == F3_JALR);
            operand2 = imm_i;
            offset = imm_i;
         end
         OPC_OP: begin
            if (funct7 == F7_SUB && funct3 == F3_ADD_SUB)
               fsel[FS_SUB] = 1'b1;
            else if (funct7 == F7_BASE)
               fsel = alu_fsel(funct3, 1'b1);
         end
         OPC_OP_IMM: begin
            // SRAI and friends fall out on the funct6 check
            fsel = alu_fsel(funct3, i_insn.i.imm[11:6] == F6_SHIFT);
            operand2 = imm_i;
         end
         OPC_BRANCH: begin
            offset = imm_b;
            case (funct3)
               F3_BEQ:  fsel[FS_BEQ]  = 1'b1;
               F3_BNE:  fsel[FS_BNE]  = 1'b1;
               F3_BLT:  fsel[FS_BLT]  = 1'b1;
               F3_BGE:  fsel[FS_BGE]  = 1'b1;
               F3_BLTU: fsel[FS_BLTU] = 1'b1;
               F3_BGEU: fsel[FS_BGEU] = 1'b1;
               default: fsel = '0;
            endcase
         end
         default: fsel = '0;
      endcase
   end

   // nothing selected means unknown opcode or funct
   assign illegal = (fsel == '0);
   assign has_rd = ~illegal & (i_insn.r.opcode != OPC_BRANCH);

   assign o_req.valid    = i_valid;
   assign o_req.illegal  = illegal;
   assign o_req.fsel     = fsel;
   assign o_req.pc       = i_pc;
   assign o_req.operand1 = i_rs1;
   assign o_req.operand2 = operand2;
   assign o_req.offset   = offset;
   assign o_req.rd       = has_rd ? i_insn.r.rd : 5'd0;

endmodule

//--- hdl/exu_pkg.sv
`include "exu_settings.svh"

package exu_pkg;

   // ##################################################
   // function select, one-hot
   // ##################################################

   typedef enum int unsigned {
      FS_LUI    = 0,
      FS_AUIPC  = 1,
      FS_JAL    = 2,
      FS_JALR   = 3,
      FS_ADD    = 4,
      FS_SUB    = 5,
      FS_AND    = 6,
      FS_OR     = 7,
      FS_XOR    = 8,
      FS_SLL    = 9,
      FS_SRL    = 10,
      FS_BEQ    = 11,
      FS_BNE    = 12,
      FS_BLT    = 13,
      FS_BGE    = 14,
      FS_BLTU   = 15,
      FS_BGEU   = 16,
      // room for later ops
      FS_SPARE0 = 17,
      FS_SPARE1 = 18,
      FS_SPARE2 = 19,
      FS_COUNT  = 20
   } exu_fsel_e;

   typedef logic [FS_COUNT-1:0] exu_fsel_t;

   // decoded request, combinational into alu and branch
   typedef struct packed {
      logic                 valid;
      logic                 illegal;
      exu_fsel_t            fsel;
      logic [`EXU_XLEN-1:0] pc;
      logic [`EXU_XLEN-1:0] operand1;
      // immediate or rs2
      logic [`EXU_XLEN-1:0] operand2;
      // branch/jump offset
      logic [`EXU_XLEN-1:0] offset;
      logic [4:0]           rd;
   } exu_req_t;

   typedef struct packed {
      logic                  valid;
      logic                  illegal;
      logic [4:0]            rd;
      logic [`EXU_XLEN-1:0]  result;
      logic                  redirect;
      logic [`EXU_PCW_W-1:0] pc_tgt;
   } exu_resp_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

   // ##################################################
   // major opcodes
   // ##################################################

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011
   } rv_opcode_e;

   // ##################################################
   // funct fields
   // ##################################################

   // alu funct3, shared by OP and OP_IMM
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL     = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // branch funct3
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   localparam logic [2:0] F3_JALR = 3'b000;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   // upper immediate bits of SLLI/SRLI on rv64
   localparam logic [5:0] F6_SHIFT = 6'b000000;

   // ##################################################
   // instruction formats
   // ##################################################

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      rv_opcode_e opcode;
   } rv_r_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      rv_opcode_e  opcode;
   } rv_i_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      rv_opcode_e  opcode;
   } rv_u_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      rv_opcode_e opcode;
   } rv_b_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      rv_opcode_e opcode;
   } rv_j_t;

   // one instruction word, read in whichever layout fits
   typedef union packed {
      rv_r_t r;
      rv_i_t i;
      rv_u_t u;
      rv_b_t b;
      rv_j_t j;
   } rv_insn_u;

endpackage

//--- include/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// ##################################################
// execute stage widths
// ##################################################

// register and operand width
`define EXU_XLEN 64

// low operand-2 bits used as shift amount
// amounts past the register width shift everything out
`define EXU_SHAMT_W 7

// word-address pc target, low two bits dropped
`define EXU_PCW_W (`EXU_XLEN - 2)

`endif
